// File: include/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// datapath widths
`define XLEN        64
`define LINE_BITS   128

// direct-mapped cache geometry
`define DC_SETS     16
`define DC_IDX_LO   4
`define DC_IDX_HI   7
`define DC_TAG_LO   8
`define DC_TAG_HI   31

// address windows, compared against the top address bits
`define CLINT_HI    8'h02     // addr[31:24], mtime / mtimecmp
`define DEV_HI      4'hA      // addr[31:28], uncached devices

`endif

// File: verilog/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    // low two bits give the width, bit 2 selects zero extension
    typedef enum logic [2:0] {
        op_w  = 3'd0,
        op_b  = 3'd1,
        op_h  = 3'd2,
        op_d  = 3'd3,
        op_wu = 3'd4,
        op_bu = 3'd5,
        op_hu = 3'd6
    } mem_op_e;

    typedef enum logic [2:0] {
        idle,
        lookup,
        refill,
        write_through,
        uncached
    } dc_state_e;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        mem_op_e          op;
        logic             write;
        logic             valid;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]        addr;
        logic                    write;
        logic                    dev;
        logic [7:0]              size;     // bytes
        logic [`LINE_BITS-1:0]   wdata;
        logic [`LINE_BITS/8-1:0] wstrb;
    } bus_req_t;

endpackage

// File: verilog/lsu_align.sv
`include "mem_consts.svh"

module lsu_align (
    input  mem_pkg::mem_op_e  op_i,
    input  logic [2:0]        offset_i,
    input  logic [`XLEN-1:0]  store_data_i,
    input  logic [`XLEN-1:0]  load_word_i,
    output logic [`XLEN-1:0]  store_word_o,
    output logic [7:0]        store_mask_o,
    output logic [`XLEN-1:0]  load_data_o
);
    import mem_pkg::*;

    logic [5:0]       shamt;
    logic [`XLEN-1:0] shifted;

    assign shamt = {offset_i, 3'b000};    // byte offset in bits

    // store side, width from the low two op bits
    always_comb begin
        case (op_i[1:0])
            2'b00: begin
                store_word_o = {32'b0, store_data_i[31:0]} << shamt;
                store_mask_o = 8'h0f << offset_i;
            end
            2'b01: begin
                store_word_o = {56'b0, store_data_i[7:0]} << shamt;
                store_mask_o = 8'h01 << offset_i;
            end
            2'b10: begin
                store_word_o = {48'b0, store_data_i[15:0]} << shamt;
                store_mask_o = 8'h03 << offset_i;
            end
            default: begin
                store_word_o = store_data_i;
                store_mask_o = 8'hff;
            end
        endcase
    end

    // move addressed bytes down to bit 0
    assign shifted = load_word_i >> shamt;

    always_comb begin
        case (op_i)
            op_w:    load_data_o = {{32{shifted[31]}}, shifted[31:0]};
            op_b:    load_data_o = {{56{shifted[7]}}, shifted[7:0]};
            op_h:    load_data_o = {{48{shifted[15]}}, shifted[15:0]};
            op_d:    load_data_o = shifted;
            op_wu:   load_data_o = {32'b0, shifted[31:0]};
            op_bu:   load_data_o = {56'b0, shifted[7:0]};
            op_hu:   load_data_o = {48'b0, shifted[15:0]};
            default: load_data_o = '0;
        endcase
    end

endmodule

// File: verilog/clint_timer.sv
`include "mem_consts.svh"

module clint_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              wen_i,
    input  logic [`XLEN-1:0]  wdata_i,
    output logic [`XLEN-1:0]  rdata_o,
    output logic              irq_o
);

    logic [`XLEN-1:0] mtime_q;
    logic [`XLEN-1:0] mtimecmp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;    // free running
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '0;
        end else if (wen_i) begin
            mtimecmp_q <= wdata_i;
        end
    end

    assign rdata_o = mtimecmp_q;
    assign irq_o   = (mtime_q >= mtimecmp_q);

endmodule

// File: verilog/dcache.sv
`include "mem_consts.svh"

module dcache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       cpu_addr_i,
    input  logic                   cpu_write_i,
    input  logic                   cpu_valid_i,
    input  logic [`XLEN-1:0]       cpu_wdata_i,
    input  logic [7:0]             cpu_wmask_i,
    output logic [`XLEN-1:0]       cpu_rdata_o,
    output logic                   cpu_ready_o,
    input  logic                   fence_i,
    output mem_pkg::bus_req_t      bus_req_o,
    output logic                   bus_valid_o,
    input  logic [`LINE_BITS-1:0]  bus_rdata_i,
    input  logic                   bus_ready_i
);
    import mem_pkg::*;

    localparam int TAG_W = `DC_TAG_HI - `DC_TAG_LO + 1;
    localparam int IDX_W = `DC_IDX_HI - `DC_IDX_LO + 1;

    dc_state_e             state_q;
    logic [`XLEN-1:0]      addr_q;
    logic [`XLEN-1:0]      wdata_q;
    logic [`XLEN-1:0]      rdata_q;
    logic [7:0]            mask_q;
    logic                  write_q;
    logic                  ready_q;
    logic [TAG_W-1:0]      tag_q [`DC_SETS];
    logic [`LINE_BITS-1:0] data_q [`DC_SETS];
    logic [`DC_SETS-1:0]   valid_q;
    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    logic                  hit;
    logic                  dev;
    logic [`XLEN-1:0]      hit_word;
    logic [`XLEN-1:0]      beat_word;
    logic [7:0]            nbytes;

    assign idx = addr_q[`DC_IDX_HI:`DC_IDX_LO];
    assign tag = addr_q[`DC_TAG_HI:`DC_TAG_LO];
    assign dev = (addr_q[31:28] == `DEV_HI);
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // addressed doubleword of the line / of the bus beat
    assign hit_word  = addr_q[3] ? data_q[idx][`LINE_BITS-1:`XLEN] : data_q[idx][`XLEN-1:0];
    assign beat_word = addr_q[3] ? bus_rdata_i[`LINE_BITS-1:`XLEN] : bus_rdata_i[`XLEN-1:0];

    // hit answers combinationally in lookup, bus paths through rdata_q
    assign cpu_ready_o = ready_q | (state_q == lookup && hit && !write_q && !dev);
    assign cpu_rdata_o = (state_q == lookup) ? hit_word : rdata_q;

    always_comb begin
        nbytes = '0;
        for (int i = 0; i < 8; i++) begin
            nbytes = nbytes + 8'(mask_q[i]);
        end
    end

    assign bus_valid_o = (state_q == refill) || (state_q == write_through) ||
                         (state_q == uncached);

    always_comb begin
        bus_req_o.addr  = {addr_q[`XLEN-1:3], 3'b000};
        bus_req_o.write = write_q;
        bus_req_o.dev   = 1'b0;
        bus_req_o.size  = 8'd8;
        bus_req_o.wdata = {2{wdata_q}};
        bus_req_o.wstrb = addr_q[3] ? {mask_q, 8'h00} : {8'h00, mask_q};
        case (state_q)
            refill: begin
                bus_req_o.addr  = {addr_q[`XLEN-1:4], 4'b0000};    // whole line
                bus_req_o.write = 1'b0;
                bus_req_o.size  = 8'd16;
                bus_req_o.wstrb = '0;
            end
            uncached: begin
                bus_req_o.addr = addr_q;
                bus_req_o.dev  = 1'b1;
                bus_req_o.size = nbytes;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
            valid_q <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state_q)
                idle: begin
                    if (fence_i) valid_q <= '0;
                    if (cpu_valid_i) state_q <= lookup;
                end
                lookup: begin
                    if (dev) state_q <= uncached;
                    else if (write_q) state_q <= write_through;
                    else if (!hit) state_q <= refill;
                    else state_q <= idle;
                end
                refill: begin
                    if (bus_ready_i) begin
                        valid_q[idx] <= 1'b1;
                        ready_q      <= 1'b1;
                        state_q      <= idle;
                    end
                end
                default: begin    // write_through, uncached
                    if (bus_ready_i) begin
                        ready_q <= 1'b1;
                        state_q <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle && cpu_valid_i) begin
            addr_q  <= cpu_addr_i;
            wdata_q <= cpu_wdata_i;
            mask_q  <= cpu_wmask_i;
            write_q <= cpu_write_i;
        end
        // store hit patches the line, no allocate on miss
        if (state_q == lookup && write_q && hit && !dev) begin
            for (int i = 0; i < 8; i++) begin
                if (mask_q[i]) data_q[idx][addr_q[3]*`XLEN + i*8 +: 8] <= wdata_q[i*8 +: 8];
            end
        end
        if (state_q == refill && bus_ready_i) begin
            data_q[idx] <= bus_rdata_i;
            tag_q[idx]  <= tag;
        end
        if (bus_valid_o && bus_ready_i) rdata_q <= beat_word;
    end

endmodule

// File: verilog/mem_stage.sv
`include "mem_consts.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::mem_req_t      req_i,
    input  logic                   fence_i_i,
    output logic [`XLEN-1:0]       rdata_o,
    output logic                   busy_o,
    output logic                   timer_irq_o,
    output mem_pkg::bus_req_t      bus_req_o,
    output logic                   bus_valid_o,
    input  logic [`LINE_BITS-1:0]  bus_rdata_i,
    input  logic                   bus_ready_i
);

    logic             vis_clint;
    logic             clint_wen;
    logic             cache_doing;
    logic             cpu_valid;
    logic             cpu_ready;
    logic [`XLEN-1:0] store_word;
    logic [7:0]       store_mask;
    logic [`XLEN-1:0] cache_rdata;
    logic [`XLEN-1:0] clint_rdata;
    logic [`XLEN-1:0] load_word;

    assign vis_clint = (req_i.addr[31:24] == `CLINT_HI);
    assign clint_wen = req_i.valid && req_i.write && vis_clint;

    // one cache operation per request
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_doing <= 1'b0;
        end else if (cpu_ready) begin
            cache_doing <= 1'b0;
        end else if (cpu_valid) begin
            cache_doing <= 1'b1;
        end
    end

    assign cpu_valid = req_i.valid && !vis_clint && !cache_doing && !cpu_ready;
    assign busy_o    = req_i.valid && !vis_clint && !cpu_ready;   // timer never stalls
    assign load_word = vis_clint ? clint_rdata : cache_rdata;

    lsu_align u_align (
        .op_i         (req_i.op),
        .offset_i     (req_i.addr[2:0]),
        .store_data_i (req_i.wdata),
        .load_word_i  (load_word),
        .store_word_o (store_word),
        .store_mask_o (store_mask),
        .load_data_o  (rdata_o)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr_i  (req_i.addr),
        .cpu_write_i (req_i.write),
        .cpu_valid_i (cpu_valid),
        .cpu_wdata_i (store_word),
        .cpu_wmask_i (store_mask),
        .cpu_rdata_o (cache_rdata),
        .cpu_ready_o (cpu_ready),
        .fence_i     (fence_i_i),
        .bus_req_o   (bus_req_o),
        .bus_valid_o (bus_valid_o),
        .bus_rdata_i (bus_rdata_i),
        .bus_ready_i (bus_ready_i)
    );

    clint_timer u_clint (
        .clk     (clk),
        .rst     (rst),
        .wen_i   (clint_wen),
        .wdata_i (req_i.wdata),    // full doubleword into mtimecmp
        .rdata_o (clint_rdata),
        .irq_o   (timer_irq_o)
    );

endmodule

// File: verif/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// File: verif/mem_model.sv
`include "mem_consts.svh"

module mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::bus_req_t      bus_req_i,
    input  logic                   bus_valid_i,
    output logic [`LINE_BITS-1:0]  bus_rdata_o,
    output logic                   bus_ready_o
);
    import mem_pkg::*;

    logic [7:0] image [4096];    // cache and device windows alias here
    int         n_reads;
    int         n_writes;
    int         n_dev;
    int         last_size;
    int         wait_cnt;

    task automatic poke(input logic [11:0] a, input logic [7:0] b);
        image[a] = b;
    endtask

    task automatic serve();
        logic [11:0] base;
        base = bus_req_i.addr[11:0] & 12'hff0;    // beat covers the whole line
        if (bus_req_i.write) begin
            for (int i = 0; i < 16; i++) begin
                if (bus_req_i.wstrb[i]) image[base + i] = bus_req_i.wdata[i*8 +: 8];
            end
            n_writes++;
        end else begin
            for (int i = 0; i < 16; i++) begin
                bus_rdata_o[i*8 +: 8] = image[base + i];
            end
            n_reads++;
        end
        if (bus_req_i.dev) begin
            n_dev++;
            last_size = bus_req_i.size;
        end
    endtask

    initial begin
        bus_ready_o = 1'b0;
        bus_rdata_o = '0;
        n_reads     = 0;
        n_writes    = 0;
        n_dev       = 0;
        last_size   = 0;
        wait_cnt    = -1;
        forever begin
            @(negedge clk);
            if (rst) begin
                bus_ready_o = 1'b0;
                wait_cnt    = -1;
            end else if (bus_ready_o) begin
                bus_ready_o = 1'b0;    // handshake done at last edge
            end else if (bus_valid_i) begin
                if (wait_cnt < 0) wait_cnt = $urandom % 6;
                if (wait_cnt == 0) begin
                    serve();
                    bus_ready_o = 1'b1;
                    wait_cnt    = -1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

// File: verif/tb_mem_stage.sv
`include "mem_consts.svh"

module tb_mem_stage;
    import mem_pkg::*;

    logic                  clk;
    logic                  rst;
    mem_req_t              req;
    logic                  fence;
    logic [`XLEN-1:0]      rdata;
    logic                  busy;
    logic                  irq;
    bus_req_t              bus_req;
    logic                  bus_valid;
    logic [`LINE_BITS-1:0] bus_rdata;
    logic                  bus_ready;

    logic [7:0]       shadow [4096];    // expected memory image
    logic [`XLEN-1:0] exp_data;
    logic [`XLEN-1:0] cyc;              // follows mtime
    int               errors;
    int               n_checks;
    logic             timed_out;

    clk_gen #(.PERIOD(8)) u_clk (.clk_o(clk));

    mem_stage uut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .fence_i_i   (fence),
        .rdata_o     (rdata),
        .busy_o      (busy),
        .timer_irq_o (irq),
        .bus_req_o   (bus_req),
        .bus_valid_o (bus_valid),
        .bus_rdata_i (bus_rdata),
        .bus_ready_i (bus_ready)
    );

    mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .bus_req_i   (bus_req),
        .bus_valid_i (bus_valid),
        .bus_rdata_o (bus_rdata),
        .bus_ready_o (bus_ready)
    );

    always @(posedge clk) begin
        if (rst) cyc <= '0;
        else cyc <= cyc + 1'b1;
    end

    // every completing load against the expected value
    always @(negedge clk) begin
        #2;
        if (!rst && req.valid && !req.write && !busy && !timed_out) begin
            n_checks++;
            if (rdata !== exp_data) begin
                errors++;
                $display("[ERROR] %0t rdata_o got %h expected %h", $time, rdata, exp_data);
            end
        end
    end

    function automatic logic [7:0] fill_byte(input int a);
        return 8'((a * 29) ^ (a >> 7) ^ 32'h5a);
    endfunction

    function automatic int op_bytes(input mem_op_e op);
        case (op[1:0])
            2'd0:    return 4;
            2'd1:    return 1;
            2'd2:    return 2;
            default: return 8;
        endcase
    endfunction

    // expected load result from a doubleword
    function automatic logic [63:0] ref_load(input logic [63:0] dword, input mem_op_e op,
                                             input logic [2:0] off);
        logic [63:0] v;
        logic [63:0] keep;
        int          nb;
        nb = op_bytes(op);
        v  = dword >> (8 * off);
        if (nb < 8) begin
            keep = (64'd1 << (8 * nb)) - 1;
            v    = v & keep;
            if (!op[2] && v[8*nb-1]) v = v | ~keep;    // sign extend
        end
        return v;
    endfunction

    function automatic logic [63:0] shadow_dword(input logic [63:0] addr);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*8 +: 8] = shadow[{addr[11:3], 3'b000} + i];
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (!timed_out) begin
            n_checks++;
            if (got !== exp) begin
                errors++;
                $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            end
        end
    endtask

    // present one request and hold it until busy_o drops
    task automatic issue(input logic [63:0] addr, input mem_op_e op, input logic wr,
                         input logic [63:0] wdata, input logic [63:0] exp);
        int n;
        if (timed_out) return;
        @(negedge clk);
        req.addr  = addr;
        req.wdata = wdata;
        req.op    = op;
        req.write = wr;
        req.valid = 1'b1;
        exp_data  = exp;
        n = 0;
        #1;
        while (busy && n < 200) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (busy) begin
            timed_out = 1'b1;
            $display("timeout: busy_o stayed high for 200 cycles at address %h", addr);
        end
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    task automatic store_mem(input logic [63:0] addr, input mem_op_e op, input logic [63:0] data);
        for (int i = 0; i < op_bytes(op); i++) begin
            shadow[addr[11:0] + i] = data[i*8 +: 8];
        end
        issue(addr, op, 1'b1, data, '0);
    endtask

    task automatic load_mem(input logic [63:0] addr, input mem_op_e op);
        issue(addr, op, 1'b0, '0, ref_load(shadow_dword(addr), op, addr[2:0]));
    endtask

    task automatic pulse_fence();
        @(negedge clk);
        fence = 1'b1;
        @(negedge clk);
        fence = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int e0);
        $display("test %0d %s: %0d errors", num, name, errors - e0);
    endtask

    task automatic sweep_widths();
        mem_op_e     op;
        int          nb;
        int          off;
        logic [63:0] base;
        logic [63:0] data;
        for (int n = 0; n < 12; n++) begin
            op   = mem_op_e'(3'(n % 4));    // w, b, h, d in turn
            nb   = op_bytes(op);
            off  = ($urandom % (8 / nb)) * nb;
            base = 64'h8000_0000 + 64'(($urandom % 64) * 8);
            data = {$urandom, $urandom};
            store_mem(base + 64'(off), op, data);
            for (int k = 0; k < 7; k++) begin
                op = mem_op_e'(3'(k));
                nb = op_bytes(op);
                load_mem(base + 64'(off - off % nb), op);
            end
        end
    endtask

    task automatic reuse_line();
        logic [63:0] a;
        int          r0;
        int          w0;
        a  = 64'h8000_0600;
        r0 = u_mem.n_reads;
        w0 = u_mem.n_writes;
        load_mem(a, op_d);    // miss fills the line
        check_eq("bus reads", u_mem.n_reads, r0 + 1);
        load_mem(a + 8, op_w);
        check_eq("bus reads", u_mem.n_reads, r0 + 1);
        store_mem(a + 4, op_w, 64'h0000_0000_c0de_7a11);
        check_eq("bus writes", u_mem.n_writes, w0 + 1);
        load_mem(a, op_d);
        check_eq("bus reads", u_mem.n_reads, r0 + 1);
    endtask

    task automatic access_device();
        logic [63:0] a;
        int          d0;
        a  = 64'hA000_0800;
        d0 = u_mem.n_dev;
        store_mem(a + 6, op_h, 64'h0000_0000_0000_beef);
        check_eq("dev transfers", u_mem.n_dev, d0 + 1);
        check_eq("bus size", u_mem.last_size, 2);
        load_mem(a + 6, op_hu);
        check_eq("dev transfers", u_mem.n_dev, d0 + 2);
        check_eq("bus size", u_mem.last_size, 2);
        load_mem(a + 6, op_hu);    // repeat is not cached
        check_eq("dev transfers", u_mem.n_dev, d0 + 3);
        load_mem(a + 7, op_b);
        check_eq("bus size", u_mem.last_size, 1);
        load_mem(a + 4, op_w);
        check_eq("bus size", u_mem.last_size, 4);
        load_mem(a, op_d);
        check_eq("bus size", u_mem.last_size, 8);
        check_eq("dev transfers", u_mem.n_dev, d0 + 6);
    endtask

    task automatic refetch_after_fence();
        logic [63:0] a;
        logic [63:0] nv;
        int          r1;
        a = 64'h8000_0700;
        load_mem(a, op_d);
        nv = ~shadow_dword(a);
        for (int i = 0; i < 8; i++) begin
            u_mem.poke(12'(a[11:0] + i), nv[i*8 +: 8]);
        end
        r1 = u_mem.n_reads;
        load_mem(a, op_d);    // stale line still answers
        check_eq("bus reads", u_mem.n_reads, r1);
        for (int i = 0; i < 8; i++) begin
            shadow[a[11:0] + i] = nv[i*8 +: 8];
        end
        pulse_fence();
        load_mem(a, op_d);
        check_eq("bus reads", u_mem.n_reads, r1 + 1);
    endtask

    task automatic compare_timer();
        logic [63:0] t;
        logic [63:0] cmp;
        int          r0;
        int          w0;
        int          n;
        t   = 64'h0200_4000;
        r0  = u_mem.n_reads;
        w0  = u_mem.n_writes;
        cmp = 64'h0123_4567_89ab_cdef;
        issue(t, op_d, 1'b1, cmp, '0);
        issue(t, op_d, 1'b0, '0, ref_load(cmp, op_d, 3'd0));
        issue(t + 4, op_wu, 1'b0, '0, ref_load(cmp, op_wu, 3'd4));
        check_eq("bus reads", u_mem.n_reads, r0);
        check_eq("bus writes", u_mem.n_writes, w0);
        cmp = cyc + 30;
        issue(t, op_d, 1'b1, cmp, '0);
        check_eq("timer_irq_o", irq, 0);
        n = 0;
        while (!irq && n < 60) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!irq) begin
            errors++;
            $display("timer_irq_o did not rise within 60 cycles");
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_eq("timer_irq_o", irq, 1);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(32'h9b08));
        rst       = 1'b1;
        req       = '0;
        fence     = 1'b0;
        exp_data  = '0;
        errors    = 0;
        n_checks  = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = fill_byte(i);
            u_mem.poke(12'(i), shadow[i]);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        sweep_widths();
        report_test(1, "store/load widths", e0);
        e0 = errors;
        reuse_line();
        report_test(2, "line reuse", e0);
        e0 = errors;
        access_device();
        report_test(3, "device window", e0);
        e0 = errors;
        refetch_after_fence();
        report_test(4, "fence.i", e0);
        e0 = errors;
        compare_timer();
        report_test(5, "timer", e0);

        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
verilog/mem_pkg.sv
verilog/lsu_align.sv
verilog/clint_timer.sv
verilog/dcache.sv
verilog/mem_stage.sv
verif/clk_gen.sv
verif/mem_model.sv
verif/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - include
    files:
      - verilog/mem_pkg.sv
      - verilog/lsu_align.sv
      - verilog/clint_timer.sv
      - verilog/dcache.sv
      - verilog/mem_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/clk_gen.sv
      - verif/mem_model.sv
      - verif/tb_mem_stage.sv
